//--- source/csrPkg.sv
/*
 * Shared constants for the CSR block: widths, the CSR address map,
 * machine ID values and the one-hot select layout used between stages.
 * Referenced by scoped name from every RTL file and the testbench.
 */
`default_nettype none

package csrPkg;

    localparam int DataWidth = 32;
    localparam int AddrWidth = 12;
    localparam int OpWidth   = 3;

    // Modify codes from the core pipeline
    localparam logic [OpWidth-1:0] OpWrite = 3'b001;
    localparam logic [OpWidth-1:0] OpSet   = 3'b010;
    localparam logic [OpWidth-1:0] OpClear = 3'b011;

    localparam logic [AddrWidth-1:0] AddrIsa      = 12'h301;
    localparam logic [AddrWidth-1:0] AddrVendorId = 12'hF11;
    localparam logic [AddrWidth-1:0] AddrArchId   = 12'hF12;
    localparam logic [AddrWidth-1:0] AddrImpId    = 12'hF13;
    localparam logic [AddrWidth-1:0] AddrHartId   = 12'hF14;
    localparam logic [AddrWidth-1:0] AddrKhz      = 12'hFC0;
    localparam logic [AddrWidth-1:0] AddrPins     = 12'hBC1;
    localparam logic [AddrWidth-1:0] AddrTimer    = 12'hBC2;

    // Counter low words, high words sit 80h above
    localparam logic [AddrWidth-1:0] AddrHiOffset = 12'h080;
    localparam logic [AddrWidth-1:0] AddrMCycle   = 12'hB00;
    localparam logic [AddrWidth-1:0] AddrCycle    = 12'hC00;
    localparam logic [AddrWidth-1:0] AddrTime     = 12'hC01;
    localparam logic [AddrWidth-1:0] AddrMInstret = 12'hB02;
    localparam logic [AddrWidth-1:0] AddrInstret  = 12'hC02;
    localparam logic [AddrWidth-1:0] AddrMCycleH   = AddrMCycle + AddrHiOffset;
    localparam logic [AddrWidth-1:0] AddrCycleH    = AddrCycle + AddrHiOffset;
    localparam logic [AddrWidth-1:0] AddrTimeH     = AddrTime + AddrHiOffset;
    localparam logic [AddrWidth-1:0] AddrMInstretH = AddrMInstret + AddrHiOffset;
    localparam logic [AddrWidth-1:0] AddrInstretH  = AddrInstret + AddrHiOffset;

    localparam int unsigned ClockRate = 12_000_000; // Hz
    localparam logic [DataWidth-1:0] IsaValue      = 32'h4000_0100; // RV32I
    localparam logic [DataWidth-1:0] VendorIdValue = 32'd0;
    localparam logic [DataWidth-1:0] ArchIdValue   = 32'd23;
    localparam logic [DataWidth-1:0] ImpIdValue    = 32'd0;
    localparam logic [DataWidth-1:0] HartIdValue   = 32'd0;
    localparam logic [DataWidth-1:0] KhzValue      = ClockRate / 1000;

    // Bit positions in the one-hot select
    localparam int SelCount     = 12;
    localparam int SelIsa       = 0;
    localparam int SelVendor    = 1;
    localparam int SelArch      = 2;
    localparam int SelImp       = 3;
    localparam int SelHart      = 4;
    localparam int SelKhz       = 5;
    localparam int SelCycleLo   = 6;
    localparam int SelCycleHi   = 7;
    localparam int SelInstretLo = 8;
    localparam int SelInstretHi = 9;
    localparam int SelPins      = 10;
    localparam int SelTimer     = 11;

    localparam int PinCount = 4;
    localparam logic [PinCount-1:0] PinsResetValue = 4'b0001;
    localparam int TimerWidth = 32;

endpackage

`default_nettype wire

//--- source/csrExecIf.sv
/*
 * Execute-stage command from the decode stage to the CSR units.
 * Valid for exactly one cycle; a unit acts only when its sel bit is set.
 */
`timescale 1ns/1ps
`default_nettype none

interface csrExecIf;

    logic [csrPkg::SelCount-1:0]  sel;     // One-hot or zero
    logic                         opWrite;
    logic                         opSet;
    logic                         opClear;
    logic [csrPkg::DataWidth-1:0] wdata;

    // Driven by the decode stage
    modport stage (output sel, opWrite, opSet, opClear, wdata);

    // Read by every unit
    modport unit (input sel, opWrite, opSet, opClear, wdata);

endinterface

`default_nettype wire

//--- source/csrDecode.sv
/*
 * D stage of a CSR access. Matches the address against the map,
 * reports valid combinationally and registers a one-hot select plus
 * the decoded operation flags for the execute stage.
 */
`timescale 1ns/1ps
`default_nettype none

module csrDecode (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire [csrPkg::AddrWidth-1:0]  addr,
    input  wire [csrPkg::OpWidth-1:0]    modify,
    input  wire [csrPkg::DataWidth-1:0]  wdata,
    output logic                         valid,
    csrExecIf.stage                      exec
);

    logic [csrPkg::SelCount-1:0] selNext;

    always_comb begin
        selNext = '0;
        selNext[csrPkg::SelIsa]    = (addr == csrPkg::AddrIsa);
        selNext[csrPkg::SelVendor] = (addr == csrPkg::AddrVendorId);
        selNext[csrPkg::SelArch]   = (addr == csrPkg::AddrArchId);
        selNext[csrPkg::SelImp]    = (addr == csrPkg::AddrImpId);
        selNext[csrPkg::SelHart]   = (addr == csrPkg::AddrHartId);
        selNext[csrPkg::SelKhz]    = (addr == csrPkg::AddrKhz);
        // Machine, user and time aliases all map onto one counter
        selNext[csrPkg::SelCycleLo] = (addr == csrPkg::AddrMCycle) |
                                      (addr == csrPkg::AddrCycle) |
                                      (addr == csrPkg::AddrTime);
        selNext[csrPkg::SelCycleHi] = (addr == csrPkg::AddrMCycleH) |
                                      (addr == csrPkg::AddrCycleH) |
                                      (addr == csrPkg::AddrTimeH);
        selNext[csrPkg::SelInstretLo] = (addr == csrPkg::AddrMInstret) |
                                        (addr == csrPkg::AddrInstret);
        selNext[csrPkg::SelInstretHi] = (addr == csrPkg::AddrMInstretH) |
                                        (addr == csrPkg::AddrInstretH);
        selNext[csrPkg::SelPins]  = (addr == csrPkg::AddrPins);
        selNext[csrPkg::SelTimer] = (addr == csrPkg::AddrTimer);
    end

    assign valid = |selNext; // Same cycle as addr

    always_ff @(posedge clk) begin
        if (!rstn) begin
            exec.sel     <= '0;
            exec.opWrite <= 1'b0;
            exec.opSet   <= 1'b0;
            exec.opClear <= 1'b0;
        end else begin
            exec.sel     <= selNext;
            exec.opWrite <= (modify == csrPkg::OpWrite);
            exec.opSet   <= (modify == csrPkg::OpSet);
            exec.opClear <= (modify == csrPkg::OpClear);
        end
    end

    always_ff @(posedge clk) begin
        exec.wdata <= wdata;
    end

endmodule

`default_nettype wire

//--- source/csrCounters.sv
/*
 * Read-only 64-bit cycle and retired-instruction counters.
 * The low word carries into the high word one cycle later, which keeps
 * the adders at 32 bits. The selected word is registered into rdata.
 */
`timescale 1ns/1ps
`default_nettype none

module csrCounters (
    input  wire                          clk,
    input  wire                          rstn,
    csrExecIf.unit                       exec,
    input  wire                          retired,
    output logic [csrPkg::DataWidth-1:0] rdata
);

    // Bit 32 of a low half holds a pending carry
    logic [csrPkg::DataWidth:0]   cycleLo;
    logic [csrPkg::DataWidth-1:0] cycleHi;
    logic [csrPkg::DataWidth:0]   instretLo;
    logic [csrPkg::DataWidth-1:0] instretHi;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cycleLo   <= '0;
            cycleHi   <= '0;
            instretLo <= '0;
            instretHi <= '0;
        end else begin
            cycleLo   <= {1'b0, cycleLo[csrPkg::DataWidth-1:0]} + 1'b1;
            cycleHi   <= cycleHi + {{(csrPkg::DataWidth-1){1'b0}},
                                    cycleLo[csrPkg::DataWidth]};
            instretLo <= {1'b0, instretLo[csrPkg::DataWidth-1:0]} + retired;
            instretHi <= instretHi + {{(csrPkg::DataWidth-1){1'b0}},
                                      instretLo[csrPkg::DataWidth]};
        end
    end

    // E stage read, zero when not selected
    always_ff @(posedge clk) begin
        rdata <= (exec.sel[csrPkg::SelCycleLo] ?
                     cycleLo[csrPkg::DataWidth-1:0] : '0)
               | (exec.sel[csrPkg::SelCycleHi] ? cycleHi : '0)
               | (exec.sel[csrPkg::SelInstretLo] ?
                     instretLo[csrPkg::DataWidth-1:0] : '0)
               | (exec.sel[csrPkg::SelInstretHi] ? instretHi : '0);
    end

endmodule

`default_nettype wire

//--- source/csrPins.sv
/*
 * Output pin register, e.g. for LEDs. Supports write, set and clear
 * on the low PinCount bits of wdata; reads return the pins zero-extended.
 */
`timescale 1ns/1ps
`default_nettype none

module csrPins (
    input  wire                          clk,
    input  wire                          rstn,
    csrExecIf.unit                       exec,
    output logic [csrPkg::PinCount-1:0]  outPins,
    output logic [csrPkg::DataWidth-1:0] rdata
);

    logic [csrPkg::PinCount-1:0] bits;

    assign bits = exec.wdata[csrPkg::PinCount-1:0];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            outPins <= csrPkg::PinsResetValue;
        end else if (exec.sel[csrPkg::SelPins]) begin
            if (exec.opWrite) begin
                outPins <= bits;
            end else if (exec.opSet) begin
                outPins <= outPins | bits;
            end else if (exec.opClear) begin
                outPins <= outPins & ~bits;
            end
        end
    end

    always_ff @(posedge clk) begin
        rdata <= exec.sel[csrPkg::SelPins] ?
                 {{(csrPkg::DataWidth-csrPkg::PinCount){1'b0}}, outPins} : '0;
    end

endmodule

`default_nettype wire

//--- source/csrTimer.sv
/*
 * Relative timer. A write loads the cycle count and arms the timer,
 * a clear disarms it. The request stays high while armed and expired.
 * Reads return nothing, so the timer address reads as zero.
 */
`timescale 1ns/1ps
`default_nettype none

module csrTimer (
    input  wire    clk,
    input  wire    rstn,
    csrExecIf.unit exec,
    output logic   irq
);

    logic [csrPkg::TimerWidth-1:0] count;
    logic                          timerOn;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            count   <= '0;
            timerOn <= 1'b0;
            irq     <= 1'b0;
        end else begin
            // Count down to zero, request one edge later
            if (count == '0) begin
                irq <= timerOn;
            end else begin
                irq   <= 1'b0;
                count <= count - 1'b1;
            end

            if (exec.sel[csrPkg::SelTimer]) begin
                if (exec.opWrite) begin
                    timerOn <= 1'b1;
                    count   <= exec.wdata[csrPkg::TimerWidth-1:0]; // Overrides decrement
                end else if (exec.opClear) begin
                    timerOn <= 1'b0; // Any value disarms
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/csrReadMerge.sv
/*
 * E stage read of the ID and clock frequency constants, and the M stage
 * OR of all unit read words into the block's read data.
 */
`timescale 1ns/1ps
`default_nettype none

module csrReadMerge (
    input  wire                          clk,
    csrExecIf.unit                       exec,
    input  wire  [csrPkg::DataWidth-1:0] countersData,
    input  wire  [csrPkg::DataWidth-1:0] pinsData,
    output logic [csrPkg::DataWidth-1:0] rdata
);

    logic [csrPkg::DataWidth-1:0] idData;

    always_ff @(posedge clk) begin
        idData <= (exec.sel[csrPkg::SelIsa]    ? csrPkg::IsaValue      : '0)
                | (exec.sel[csrPkg::SelVendor] ? csrPkg::VendorIdValue : '0)
                | (exec.sel[csrPkg::SelArch]   ? csrPkg::ArchIdValue   : '0)
                | (exec.sel[csrPkg::SelImp]    ? csrPkg::ImpIdValue    : '0)
                | (exec.sel[csrPkg::SelHart]   ? csrPkg::HartIdValue   : '0)
                | (exec.sel[csrPkg::SelKhz]    ? csrPkg::KhzValue      : '0);
    end

    // Unselected words are zero, so OR acts as the mux
    assign rdata = idData | countersData | pinsData;

endmodule

`default_nettype wire

//--- source/csrTop.sv
/*
 * CSR block of the core. An access is decoded in D, performed by the
 * units in E and merged in M; rdata is stable two edges after the access.
 * Plain ports towards the pipeline and the board.
 */
`timescale 1ns/1ps
`default_nettype none

module csrTop (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire  [csrPkg::AddrWidth-1:0] addr,
    input  wire  [csrPkg::OpWidth-1:0]   modify,
    input  wire  [csrPkg::DataWidth-1:0] wdata,
    output logic [csrPkg::DataWidth-1:0] rdata,
    output logic                         valid,
    input  wire                          retired,
    output logic [csrPkg::PinCount-1:0]  outPins,
    output logic                         irqTimer
);

    logic [csrPkg::DataWidth-1:0] countersData;
    logic [csrPkg::DataWidth-1:0] pinsData;

    csrExecIf exec ();

    csrDecode uDecode (
        .clk    (clk),
        .rstn   (rstn),
        .addr   (addr),
        .modify (modify),
        .wdata  (wdata),
        .valid  (valid),
        .exec   (exec)
    );

    csrCounters uCounters (
        .clk     (clk),
        .rstn    (rstn),
        .exec    (exec),
        .retired (retired),
        .rdata   (countersData)
    );

    csrPins uPins (
        .clk     (clk),
        .rstn    (rstn),
        .exec    (exec),
        .outPins (outPins),
        .rdata   (pinsData)
    );

    csrTimer uTimer (
        .clk  (clk),
        .rstn (rstn),
        .exec (exec),
        .irq  (irqTimer)
    );

    csrReadMerge uReadMerge (
        .clk          (clk),
        .exec         (exec),
        .countersData (countersData),
        .pinsData     (pinsData),
        .rdata        (rdata)
    );

endmodule

`default_nettype wire

//--- tests/csrTb.sv
/*
 * Testbench for the CSR block. Random accesses from an xorshift generator
 * are checked against models of the ID map, pins, counters and timer.
 * Expected read results wait in a queue tagged with the edge of their check.
 */
`timescale 1ns/1ps
`default_nettype none

module csrTb;

    localparam int AccessTotal = 87; // Accesses issued over all tests
    localparam int MappedCount = 18;

    logic                         clk = 1'b0;
    logic                         rstn;
    logic [csrPkg::AddrWidth-1:0] addr;
    logic [csrPkg::OpWidth-1:0]   modify;
    logic [csrPkg::DataWidth-1:0] wdata;
    logic [csrPkg::DataWidth-1:0] rdata;
    logic                         valid;
    logic                         retired;
    logic [csrPkg::PinCount-1:0]  outPins;
    logic                         irqTimer;

    logic [31:0] rngState = 32'd97988;
    int          curEdge = 0;   // Rising edges seen so far
    int          errorCount = 0;
    int          checkCount = 0;
    int          tagQ[$];       // Edge at which the result must be stable
    int          kindQ[$];      // 0 compare rdata, 1 capture rdata, 2 compare outPins
    logic [31:0] valQ[$];
    logic [31:0] capQ[$];
    int          pendKind;
    logic [31:0] pendVal;

    csrTop u_dut (
        .clk      (clk),
        .rstn     (rstn),
        .addr     (addr),
        .modify   (modify),
        .wdata    (wdata),
        .rdata    (rdata),
        .valid    (valid),
        .retired  (retired),
        .outPins  (outPins),
        .irqTimer (irqTimer)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        curEdge <= curEdge + 1;
    end

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // IDs first, then timer, pins and the counter aliases
    function automatic logic [csrPkg::AddrWidth-1:0] mapAddr(input int i);
        case (i)
            0: return csrPkg::AddrIsa;
            1: return csrPkg::AddrVendorId;
            2: return csrPkg::AddrArchId;
            3: return csrPkg::AddrImpId;
            4: return csrPkg::AddrHartId;
            5: return csrPkg::AddrKhz;
            6: return csrPkg::AddrTimer;
            7: return csrPkg::AddrPins;
            8: return csrPkg::AddrMCycle;
            9: return csrPkg::AddrCycle;
            10: return csrPkg::AddrTime;
            11: return csrPkg::AddrMInstret;
            12: return csrPkg::AddrInstret;
            13: return csrPkg::AddrMCycleH;
            14: return csrPkg::AddrCycleH;
            15: return csrPkg::AddrTimeH;
            16: return csrPkg::AddrMInstretH;
            17: return csrPkg::AddrInstretH;
            default: return '0;
        endcase
    endfunction

    function automatic logic [31:0] idValue(input int i);
        case (i)
            0: return csrPkg::IsaValue;
            1: return csrPkg::VendorIdValue;
            2: return csrPkg::ArchIdValue;
            3: return csrPkg::ImpIdValue;
            4: return csrPkg::HartIdValue;
            5: return csrPkg::KhzValue;
            default: return '0; // Timer and unmapped addresses
        endcase
    endfunction

    function automatic bit isMapped(input logic [csrPkg::AddrWidth-1:0] a);
        bit hit;
        hit = 1'b0;
        for (int i = 0; i < MappedCount; i++) begin
            if (mapAddr(i) == a) hit = 1'b1;
        end
        return hit;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] expected, input string what);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("error at %0t ns: %s got %h expected %h", $time, what, got, expected);
        end
    endtask

    task automatic expectAt(input int tag, input int kind, input logic [31:0] value);
        tagQ.push_back(tag);
        kindQ.push_back(kind);
        valQ.push_back(value);
    endtask

    // Called on a rising edge, returns the edge that samples the access
    task automatic access(input logic [csrPkg::AddrWidth-1:0] a,
                          input logic [csrPkg::OpWidth-1:0] m,
                          input logic [31:0] d, input int kind, input logic [31:0] value,
                          output int sampleEdge);
        addr   <= a;
        modify <= m;
        wdata  <= d;
        @(negedge clk);
        sampleEdge = curEdge + 1;
        check(32'(valid), 32'(isMapped(a)), "valid");
        if (kind >= 0) expectAt(sampleEdge + 2, kind, value);
        @(posedge clk);
    endtask

    task automatic idle(input int cycles);
        addr   <= '0; // Unmapped
        modify <= '0;
        wdata  <= '0;
        repeat (cycles) @(posedge clk);
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        $display("test %s finished with %0d errors", name, errorCount - errorsBefore);
    endtask

    // Results due at the next edge are stable here
    always @(negedge clk) begin
        while (tagQ.size() > 0 && tagQ[0] == curEdge + 1) begin
            pendKind = kindQ.pop_front();
            pendVal  = valQ.pop_front();
            tagQ.delete(0);
            if (pendKind == 1) capQ.push_back(rdata);
            else if (pendKind == 2) check(32'(outPins), pendVal, "outPins");
            else check(rdata, pendVal, "rdata");
        end
    end

    initial begin
        repeat (AccessTotal * 64) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", AccessTotal * 64);
        $display("Test failed");
        $finish;
    end

    initial begin
        int e;
        int k;
        int n;
        int idx;
        int errBefore;
        int pulses;
        logic [31:0] r;
        logic [csrPkg::AddrWidth-1:0] a;
        logic [csrPkg::OpWidth-1:0] op;
        logic [csrPkg::PinCount-1:0] pinModel;

        rstn    = 1'b0;
        addr    = '0;
        modify  = '0;
        wdata   = '0;
        retired = 1'b0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);

        errBefore = errorCount;
        repeat (40) begin
            r = nextRand();
            if (r[0]) begin
                idx = int'(r[15:8]) % MappedCount;
                a = mapAddr(idx);
            end else begin
                idx = -1;
                a = r[27:16];
                if (isMapped(a)) a = '0;
            end
            // Pins and counters hold state, only valid is checked there
            if (idx >= 7) access(a, '0, r, -1, '0, e);
            else access(a, '0, r, 0, idValue(idx), e);
        end
        idle(4);
        finishTest("ids", errBefore);

        errBefore = errorCount;
        @(negedge clk);
        check(32'(outPins), 32'(csrPkg::PinsResetValue), "outPins after reset");
        @(posedge clk);
        pinModel = csrPkg::PinsResetValue;
        repeat (30) begin
            r = nextRand();
            case (r[31:30])
                2'd1: op = csrPkg::OpWrite;
                2'd2: op = csrPkg::OpSet;
                2'd3: op = csrPkg::OpClear;
                default: op = '0;
            endcase
            access(csrPkg::AddrPins, op, r, 0, 32'(pinModel), e); // Reads the old value
            if (op == csrPkg::OpWrite) pinModel = r[csrPkg::PinCount-1:0];
            else if (op == csrPkg::OpSet) pinModel = pinModel | r[csrPkg::PinCount-1:0];
            else if (op == csrPkg::OpClear) pinModel = pinModel & ~r[csrPkg::PinCount-1:0];
            expectAt(e + 2, 2, 32'(pinModel));
        end
        idle(4);
        finishTest("pins", errBefore);

        errBefore = errorCount;
        k = 1 + int'(nextRand() % 16);
        access(csrPkg::AddrMCycle, '0, '0, 1, '0, e);
        idle(k - 1);
        access(csrPkg::AddrMCycle, '0, '0, 1, '0, e);
        access(csrPkg::AddrCycle, '0, '0, 1, '0, e);
        access(csrPkg::AddrTime, '0, '0, 1, '0, e);
        access(csrPkg::AddrMCycleH, '0, '0, 0, '0, e);
        access(csrPkg::AddrCycleH, '0, '0, 0, '0, e);
        access(csrPkg::AddrTimeH, '0, '0, 0, '0, e);
        idle(4);
        check(capQ[1] - capQ[0], 32'(k), "cycle delta over k cycles");
        check(capQ[2] - capQ[1], 32'd1, "cycle delta C00 after B00");
        check(capQ[3] - capQ[2], 32'd1, "cycle delta C01 after C00");
        finishTest("cycle", errBefore);

        errBefore = errorCount;
        pulses = 0;
        repeat (48) begin
            r = nextRand();
            retired <= r[0];
            pulses += int'(r[0]);
            @(posedge clk);
        end
        retired <= 1'b0;
        repeat (3) @(posedge clk);
        access(csrPkg::AddrInstret, '0, '0, 0, 32'(pulses), e);
        access(csrPkg::AddrMInstret, '0, '0, 0, 32'(pulses), e);
        access(csrPkg::AddrInstretH, '0, '0, 0, '0, e);
        access(csrPkg::AddrMInstretH, '0, '0, 0, '0, e);
        idle(4);
        finishTest("instret", errBefore);

        errBefore = errorCount;
        repeat (3) begin
            n = 1 + int'(nextRand() % 40);
            access(csrPkg::AddrTimer, csrPkg::OpWrite, 32'(n), -1, '0, e);
            idle(0);
            repeat (n + 6) begin
                @(negedge clk);
                check(32'(irqTimer), 32'(curEdge >= e + n + 2), "irqTimer after write");
            end
            @(posedge clk);
            access(csrPkg::AddrTimer, csrPkg::OpClear, '0, 0, '0, e); // Reads zero
            idle(0);
            repeat (4) begin
                @(negedge clk);
                check(32'(irqTimer), 32'(curEdge < e + 2), "irqTimer after clear");
            end
            @(posedge clk);
        end
        idle(4);
        finishTest("timer", errBefore);

        if (tagQ.size() != 0) begin
            $display("%0d queued result checks never ran", tagQ.size());
            errorCount++;
        end
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
source/csrPkg.sv
source/csrExecIf.sv
source/csrDecode.sv
source/csrCounters.sv
source/csrPins.sv
source/csrTimer.sv
source/csrReadMerge.sv
source/csrTop.sv
tests/csrTb.sv

//--- Makefile
# Verilator build and run of the CSR block testbench
VERILATOR ?= verilator
TOP       ?= csrTb
FILELIST  ?= project.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The simulation result is decided by the pass line in the log
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
